// File: hdl/mmu_consts.svh
// mmu geometry constants, included by the package, the RTL and the testbench
`ifndef MMU_CONSTS_SVH
`define MMU_CONSTS_SVH

// tlb geometry
`define TLB_SETS      16
`define TLB_IDX_BITS  4

// virtual address split
`define PAGE_BITS     12 // 4 KiB pages
`define VPN1_BITS     10 // level 1 table index
`define VPN0_BITS     10 // level 0 table index

// page table entry
`define PTE_VALID_BIT 0

// table walk depth
`define WALK_LEVELS   2

`endif

// File: hdl/mmu_pkg.sv
// shared mmu types and state encodings, imported by every RTL module
`include "mmu_consts.svh"

package mmu_pkg;

	typedef logic [31:0] vaddr_t;
	typedef logic [31:0] paddr_t;
	typedef logic [`VPN1_BITS+`VPN0_BITS-1:0] vpn_t;
	typedef logic [32-`PAGE_BITS-1:0] ppn_t;
	typedef logic [`VPN1_BITS+`VPN0_BITS-`TLB_IDX_BITS-1:0] tlb_tag_t; // vpn above the set index
	typedef logic [`TLB_IDX_BITS-1:0] tlb_idx_t;
	typedef logic [31:0] pte_t; // ppn in upper bits, valid in bit 0

	typedef enum logic [2:0] {
		walk_idle,
		walk_l1_addr,
		walk_l1_data,
		walk_l0_addr,
		walk_l0_data,
		walk_done
	} walk_state_t;

	typedef enum logic [1:0] {
		tlb_idle,
		tlb_lookup,
		tlb_wait_walk
	} tlb_state_t;

endpackage

// File: hdl/walk_if.sv
// walk request from the tlb to the page walker and the walk result back
`timescale 1ns/100ps

interface walk_if import mmu_pkg::*; ();

	logic walk_start; // one cycle
	vpn_t walk_vpn;   // held until walk_done
	logic walk_done;  // one cycle per start
	ppn_t walk_ppn;
	logic walk_fault;

	modport tlb (
		output walk_start,
		output walk_vpn,
		input  walk_done,
		input  walk_ppn,
		input  walk_fault
	);

	modport walker (
		input  walk_start,
		input  walk_vpn,
		output walk_done,
		output walk_ppn,
		output walk_fault
	);

endinterface

// File: hdl/tlb_array.sv
// two-way set-associative tlb with lru refill, flush and requester handshake
`timescale 1ns/100ps
`include "mmu_consts.svh"

module tlb_array import mmu_pkg::*; (
	input  logic   clk,
	input  logic   reset,
	input  logic   req_valid,
	input  vaddr_t req_vaddr,
	input  logic   flush,
	output logic   req_ready,
	output logic   resp_valid,
	output paddr_t resp_paddr,
	output logic   resp_fault,
	walk_if.tlb    walk
);

	tlb_state_t state;
	vaddr_t req_q;

	tlb_tag_t tag_mem [2][`TLB_SETS];
	ppn_t ppn_mem [2][`TLB_SETS];
	logic [`TLB_SETS-1:0] valid_mem [2];
	logic [`TLB_SETS-1:0] lru; // way to replace next

	tlb_idx_t idx;
	tlb_tag_t tag;
	logic [1:0] hit;
	logic hit_way;
	ppn_t hit_ppn;
	logic accept;
	logic lookup_hit;
	logic walk_end;
	logic refill;

	assign idx = req_q[`PAGE_BITS +: `TLB_IDX_BITS];
	assign tag = req_q[`PAGE_BITS + `TLB_IDX_BITS +: $bits(tlb_tag_t)];

	assign hit[0] = valid_mem[0][idx] && (tag_mem[0][idx] == tag);
	assign hit[1] = valid_mem[1][idx] && (tag_mem[1][idx] == tag);
	assign hit_way = hit[1];
	assign hit_ppn = ppn_mem[hit_way][idx];

	assign req_ready = (state == tlb_idle) && !flush; // flush wins over a request
	assign accept = req_valid && req_ready;
	assign lookup_hit = (state == tlb_lookup) && (hit != 2'b00);
	assign walk_end = (state == tlb_wait_walk) && walk.walk_done;
	assign refill = walk_end && !walk.walk_fault; // faults are not cached

	assign walk.walk_start = (state == tlb_lookup) && (hit == 2'b00);
	assign walk.walk_vpn = req_q[`PAGE_BITS +: $bits(vpn_t)];

	// control state
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= tlb_idle;
			resp_valid <= 1'b0;
			valid_mem[0] <= '0;
			valid_mem[1] <= '0;
			lru <= '0;
		end else begin
			resp_valid <= 1'b0;
			case (state)
				tlb_idle: begin
					if (flush) begin
						valid_mem[0] <= '0;
						valid_mem[1] <= '0;
						lru <= '0;
					end else if (accept) begin
						state <= tlb_lookup;
					end
				end
				tlb_lookup: begin
					if (lookup_hit) begin
						resp_valid <= 1'b1;
						lru[idx] <= ~hit_way; // other way becomes lru
						state <= tlb_idle;
					end else begin
						state <= tlb_wait_walk;
					end
				end
				tlb_wait_walk: begin
					if (walk_end) begin
						resp_valid <= 1'b1;
						state <= tlb_idle;
					end
					if (refill) begin
						valid_mem[lru[idx]][idx] <= 1'b1;
						lru[idx] <= ~lru[idx];
					end
				end
				default: state <= tlb_idle;
			endcase
		end
	end

	// request, response and entry payload
	always_ff @(posedge clk) begin
		if (accept) begin
			req_q <= req_vaddr;
		end
		if (lookup_hit) begin
			resp_paddr <= {hit_ppn, req_q[`PAGE_BITS-1:0]};
			resp_fault <= 1'b0;
		end
		if (walk_end) begin
			resp_fault <= walk.walk_fault;
			if (walk.walk_fault) begin
				resp_paddr <= '0;
			end else begin
				resp_paddr <= {walk.walk_ppn, req_q[`PAGE_BITS-1:0]};
			end
		end
		if (refill) begin
			tag_mem[lru[idx]][idx] <= tag;
			ppn_mem[lru[idx]][idx] <= walk.walk_ppn;
		end
	end

	// a tag lives in at most one way of its set
	a_single_way_hit: assert property (@(posedge clk) disable iff (reset)
		(state == tlb_lookup) |-> $onehot0(hit))
		else $error("both tlb ways hit in set %0d", idx);

	// walk results only arrive while a walk is awaited
	a_done_when_waiting: assert property (@(posedge clk) disable iff (reset)
		walk.walk_done |-> (state == tlb_wait_walk))
		else $error("walk_done while no walk is pending");

endmodule

// File: hdl/page_walker.sv
// two-level page table walker, reads entries over an axi4-lite read channel
`timescale 1ns/100ps
`include "mmu_consts.svh"

module page_walker import mmu_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  paddr_t     ptbr,
	input  logic       m_arready,
	input  logic       m_rvalid,
	input  pte_t       m_rdata,
	input  logic [1:0] m_rresp,
	output paddr_t     m_araddr,
	output logic       m_arvalid,
	output logic       m_rready,
	walk_if.walker     walk
);

	walk_state_t state;
	paddr_t araddr_q;
	logic fault_q;
	ppn_t ppn_q;

	ppn_t pte_ppn;
	logic pte_bad;
	logic beat;

	assign pte_ppn = m_rdata[$bits(pte_t)-1 -: $bits(ppn_t)];
	assign pte_bad = (m_rresp != 2'b00) || !m_rdata[`PTE_VALID_BIT]; // slverr or invalid entry
	assign beat = m_rvalid && m_rready;

	assign m_arvalid = (state == walk_l1_addr) || (state == walk_l0_addr);
	assign m_rready = (state == walk_l1_data) || (state == walk_l0_data);
	assign m_araddr = araddr_q;

	assign walk.walk_done = (state == walk_done);
	assign walk.walk_ppn = ppn_q;
	assign walk.walk_fault = fault_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= walk_idle;
		end else begin
			case (state)
				walk_idle: begin
					if (walk.walk_start) state <= walk_l1_addr;
				end
				walk_l1_addr: begin
					if (m_arready) state <= walk_l1_data;
				end
				walk_l1_data: begin
					if (beat) begin
						if (pte_bad) begin
							state <= walk_done; // no level 0 read
						end else begin
							state <= walk_l0_addr;
						end
					end
				end
				walk_l0_addr: begin
					if (m_arready) state <= walk_l0_data;
				end
				walk_l0_data: begin
					if (beat) state <= walk_done;
				end
				walk_done: state <= walk_idle;
				default: state <= walk_idle;
			endcase
		end
	end

	// entry addresses and walk result
	always_ff @(posedge clk) begin
		if ((state == walk_idle) && walk.walk_start) begin
			araddr_q <= ptbr + paddr_t'({walk.walk_vpn[`VPN0_BITS +: `VPN1_BITS], 2'b00});
			fault_q <= 1'b0;
			ppn_q <= '0;
		end
		if ((state == walk_l1_data) && beat) begin
			fault_q <= pte_bad;
			araddr_q <= (paddr_t'(pte_ppn) << `PAGE_BITS)
				+ paddr_t'({walk.walk_vpn[`VPN0_BITS-1:0], 2'b00});
		end
		if ((state == walk_l0_data) && beat) begin
			fault_q <= pte_bad;
			ppn_q <= pte_ppn;
		end
	end

	// axi address held while the slave stalls
	a_araddr_stable: assert property (@(posedge clk) disable iff (reset)
		(m_arvalid && !m_arready) |=> (m_arvalid && $stable(m_araddr)))
		else $error("araddr changed while arvalid waiting");

	// the tlb starts a walk only while the walker is idle
	a_start_when_idle: assert property (@(posedge clk) disable iff (reset)
		walk.walk_start |-> (state == walk_idle))
		else $error("walk_start while a walk is running");

endmodule

// File: hdl/mmu_top.sv
// mmu top level, joins the tlb and the page walker behind plain ports
`timescale 1ns/100ps

module mmu_top import mmu_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       req_valid,
	input  vaddr_t     req_vaddr,
	input  logic       flush,
	input  paddr_t     ptbr,
	input  logic       m_arready,
	input  logic       m_rvalid,
	input  pte_t       m_rdata,
	input  logic [1:0] m_rresp,
	output logic       req_ready,
	output logic       resp_valid,
	output paddr_t     resp_paddr,
	output logic       resp_fault,
	output paddr_t     m_araddr,
	output logic       m_arvalid,
	output logic       m_rready
);

	walk_if walk_bus ();

	tlb_array tlb_array_inst (
		.clk        (clk),
		.reset      (reset),
		.req_valid  (req_valid),
		.req_vaddr  (req_vaddr),
		.flush      (flush),
		.req_ready  (req_ready),
		.resp_valid (resp_valid),
		.resp_paddr (resp_paddr),
		.resp_fault (resp_fault),
		.walk       (walk_bus.tlb)
	);

	page_walker page_walker_inst (
		.clk       (clk),
		.reset     (reset),
		.ptbr      (ptbr),
		.m_arready (m_arready),
		.m_rvalid  (m_rvalid),
		.m_rdata   (m_rdata),
		.m_rresp   (m_rresp),
		.m_araddr  (m_araddr),
		.m_arvalid (m_arvalid),
		.m_rready  (m_rready),
		.walk      (walk_bus.walker)
	);

endmodule

// File: dv/mmu_tb.sv
// mmu testbench, random translations against a tlb model and a sparse page table in memory
`timescale 1ns/100ps
`include "mmu_consts.svh"

module mmu_tb import mmu_pkg::*; ();

	localparam int pool_size = 64;
	localparam int max_requests = 256; // bound over all tests
	localparam int walk_cycles = 32; // worst-case miss with stalls
	localparam paddr_t table_base = 32'h0010_0000;

	logic clk;
	logic reset;
	logic req_valid;
	vaddr_t req_vaddr;
	logic flush;
	paddr_t ptbr;
	logic m_arready;
	logic m_rvalid;
	pte_t m_rdata;
	logic [1:0] m_rresp;
	logic req_ready;
	logic resp_valid;
	paddr_t resp_paddr;
	logic resp_fault;
	paddr_t m_araddr;
	logic m_arvalid;
	logic m_rready;

	logic [31:0] lfsr = 32'h6f81_0f4e;
	pte_t page_mem [paddr_t];
	vpn_t vpn_pool [pool_size];
	ppn_t exp_ppn [pool_size];
	int kind [pool_size]; // 0 valid, 1 level 1 fault, 2 level 0 fault
	vpn_t model_vpn [2][`TLB_SETS];
	logic model_valid [2][`TLB_SETS];
	logic model_lru [`TLB_SETS];
	int errors = 0;
	int requests = 0;
	int read_count = 0;
	int resp_count = 0;
	int test_errors;
	int test_requests;
	string test_name;

	mmu_top mmu_top_inst (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// galois lfsr, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		int k;
		v = '0;
		for (k = 0; k < n; k++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic int model_lookup(input vpn_t v);
		tlb_idx_t s;
		int w;
		int k;
		s = v[`TLB_IDX_BITS-1:0];
		w = -1;
		for (k = 0; k < 2; k++) begin
			if (model_valid[k][s] && model_vpn[k][s] == v) w = k;
		end
		return w;
	endfunction

	function automatic void model_update(input vpn_t v, input int way, input bit fault);
		tlb_idx_t s;
		s = v[`TLB_IDX_BITS-1:0];
		if (way >= 0) begin
			model_lru[s] = (way == 0); // other way next
		end else if (!fault) begin
			model_vpn[model_lru[s]][s] = v;
			model_valid[model_lru[s]][s] = 1'b1;
			model_lru[s] = !model_lru[s];
		end
	endfunction

	function automatic void model_flush();
		int k;
		for (k = 0; k < `TLB_SETS; k++) begin
			model_valid[0][k] = 1'b0;
			model_valid[1][k] = 1'b0;
			model_lru[k] = 1'b0;
		end
	endfunction

	task automatic build_table();
		logic [31:0] r;
		logic [19:0] l0_ppn;
		paddr_t l1_addr;
		paddr_t l0_addr;
		int i;
		for (i = 0; i < pool_size; i++) begin
			r = rand_bits(10);
			vpn_pool[i] = {r[9:6], i[5:0], r[5:0], i[3:0]}; // set index from i
			r = rand_bits(3);
			kind[i] = (r[2:0] == 3'd0) ? 1 : (r[2:0] == 3'd1) ? 2 : 0;
			if (i == 0 || i == 16 || i == 32) kind[i] = 0; // lru set
			if (i == 48 || i == 51) kind[i] = 2;
			if (i == 49) kind[i] = 1;
			r = rand_bits(20);
			exp_ppn[i] = r[19:0];
			l0_ppn = 20'h00400 + i[19:0];
			l1_addr = table_base + {20'd0, vpn_pool[i][19:10], 2'b00};
			l0_addr = {l0_ppn, 12'd0} + {20'd0, vpn_pool[i][9:0], 2'b00};
			if (kind[i] == 1) begin
				page_mem[l1_addr] = {exp_ppn[i], 12'h000}; // valid flag clear
			end else begin
				page_mem[l1_addr] = {l0_ppn, 12'h001};
			end
			// even level 0 faults store an entry without the valid flag, odd ones answer slverr
			if (kind[i] == 0) begin
				page_mem[l0_addr] = {exp_ppn[i], 12'h001};
			end else if (kind[i] == 2 && !i[0]) begin
				page_mem[l0_addr] = {exp_ppn[i], 12'h000};
			end
		end
	endtask

	task automatic translate(input int page);
		logic [31:0] r;
		vaddr_t vaddr;
		paddr_t exp_paddr;
		int way;
		int exp_reads;
		int reads_before;
		int cycles;
		r = rand_bits(`PAGE_BITS);
		vaddr = {vpn_pool[page], r[`PAGE_BITS-1:0]};
		way = model_lookup(vpn_pool[page]);
		exp_paddr = (kind[page] == 0) ? {exp_ppn[page], vaddr[`PAGE_BITS-1:0]} : '0;
		exp_reads = (way >= 0) ? 0 : (kind[page] == 1) ? 1 : 2;
		if (!req_ready) begin
			$display("%s: req_ready low while the mmu is idle, page %0d",
				test_name, page);
			errors++;
		end
		req_valid = 1'b1;
		req_vaddr = vaddr;
		reads_before = read_count;
		@(posedge clk); // accept edge
		@(negedge clk);
		req_valid = 1'b0;
		cycles = 0;
		while (!resp_valid) begin
			if (req_ready) begin
				$display("%s: req_ready high before the response, page %0d",
					test_name, page);
				errors++;
			end
			@(negedge clk);
			cycles++;
		end
		requests++;
		if (resp_paddr !== exp_paddr) begin
			$display("Mismatch %s paddr page %0d: expected %h, actual %h",
				test_name, page, exp_paddr, resp_paddr);
			errors++;
		end
		if (resp_fault !== (kind[page] != 0)) begin
			$display("Mismatch %s fault page %0d: expected %0d, actual %0d",
				test_name, page, kind[page] != 0, resp_fault);
			errors++;
		end
		if (read_count - reads_before != exp_reads) begin
			$display("Mismatch %s reads page %0d: expected %0d, actual %0d",
				test_name, page, exp_reads, read_count - reads_before);
			errors++;
		end
		if (way >= 0 && cycles != 1) begin
			$display("Mismatch %s hit latency page %0d: expected 1, actual %0d",
				test_name, page, cycles);
			errors++;
		end
		model_update(vpn_pool[page], way, kind[page] != 0);
	endtask

	task automatic do_flush();
		flush = 1'b1;
		@(negedge clk);
		if (req_ready) begin
			$display("%s: req_ready high while flush is asserted", test_name);
			errors++;
		end
		flush = 1'b0;
		@(negedge clk);
		model_flush();
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errors = errors;
		test_requests = requests;
	endtask

	task automatic close_test();
		$display("%s: %0d requests, %0d errors", test_name, requests - test_requests,
			errors - test_errors);
	endtask

	// axi4-lite read slave with 0 to 3 stall cycles per channel
	initial begin : axi_responder
		paddr_t addr;
		logic [31:0] r;
		m_arready = 1'b0;
		m_rvalid = 1'b0;
		m_rdata = '0;
		m_rresp = 2'b00;
		forever begin
			@(negedge clk);
			if (m_arvalid) begin
				if (m_rready) begin
					$display("rready high during the address phase, address %h", m_araddr);
					errors++;
				end
				r = rand_bits(2);
				repeat (r[1:0]) @(negedge clk);
				m_arready = 1'b1;
				addr = m_araddr;
				read_count++;
				@(negedge clk);
				m_arready = 1'b0;
				r = rand_bits(2);
				repeat (r[1:0]) @(negedge clk);
				m_rvalid = 1'b1;
				if (page_mem.exists(addr)) begin
					m_rdata = page_mem[addr];
					m_rresp = 2'b00;
				end else begin
					m_rdata = 32'hffff_ffff; // valid bit set, only slverr faults
					m_rresp = 2'b10;
				end
				if (!m_rready) begin
					$display("rready low while read data is waiting, address %h", addr);
					errors++;
				end
				@(negedge clk); // rready is high in the data state
				m_rvalid = 1'b0;
			end
		end
	end

	always @(negedge clk) begin
		if (!reset && resp_valid) resp_count++;
	end

	initial begin
		#(100 * (8 + max_requests * walk_cycles));
		$display("timeout: the run did not finish within the expected number of cycles");
		$display("test failed");
		$finish;
	end

	initial begin
		logic [31:0] r;
		int i;
		int p;
		reset = 1'b1;
		req_valid = 1'b0;
		req_vaddr = '0;
		flush = 1'b0;
		ptbr = table_base;
		build_table();
		model_flush();
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		if (!req_ready || resp_valid || m_arvalid || m_rready) begin
			$display("outputs not at their idle values after reset");
			errors++;
		end
		start_test("translation");
		for (i = 0; i < pool_size; i++) begin
			if (kind[i] == 0) translate(i);
		end
		close_test();
		start_test("page_fault");
		for (i = 0; i < pool_size; i++) begin
			if (kind[i] != 0) begin
				translate(i);
				translate(i); // walks again, faults are not cached
			end
		end
		close_test();
		start_test("hit_timing");
		repeat (16) begin
			r = rand_bits(6);
			p = int'(r[5:0]);
			repeat (4) translate(p);
		end
		close_test();
		start_test("lru");
		do_flush();
		translate(0);
		translate(16);
		translate(0);
		translate(32); // evicts 16
		translate(16);
		translate(48); // faults, set untouched
		translate(0);
		translate(32);
		translate(16);
		close_test();
		start_test("flush");
		translate(0);
		translate(0);
		do_flush();
		translate(0);
		close_test();
		start_test("back_pressure");
		repeat (40) begin
			r = rand_bits(6);
			p = int'(r[5:0]);
			translate(p);
		end
		@(negedge clk);
		if (resp_count != requests) begin
			$display("%0d responses seen for %0d requests", resp_count, requests);
			errors++;
		end
		close_test();
		$display("%0d requests, %0d axi reads, %0d errors", requests, read_count, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// File: filelist.f
+incdir+hdl
hdl/mmu_pkg.sv
hdl/walk_if.sv
hdl/tlb_array.sv
hdl/page_walker.sv
hdl/mmu_top.sv
dv/mmu_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f filelist.f --top-module mmu_tb -o mmu_sim || exit 1
out=$(./obj_dir/mmu_sim)
echo "$out"
echo "$out" | grep -qx "test passed" && exit 0 || exit 1
